//--- design/rv_core_pkg.sv
package rv_core_pkg;

    localparam int XLEN = 32;
    localparam int NREGS = 16;
    localparam logic [XLEN-1:0] RESET_PC = '0;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [3:0] reg_idx_t;
    typedef logic [3:0] strb_t;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
    } br_op_t;

    // Encoded like funct3[1:0] of loads and stores.
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_t;

    typedef enum logic [1:0] {IFU_IDLE, IFU_REQ, IFU_WAIT, IFU_HOLD} ifu_state_t;

    typedef enum logic [1:0] {LSU_IDLE, LSU_REQ, LSU_WAIT} lsu_state_t;

    typedef struct packed {
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        word_t     imm;
        alu_op_t   alu_op;
        logic      a_pc;        // Operand A is the PC.
        logic      b_imm;       // Operand B is the immediate.
        br_op_t    br_op;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        mem_size_t mem_size;
        logic      mem_unsigned;
        logic      halt;
        logic      illegal;
    } decoded_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        strb_t strb;
        logic  we;
    } mem_req_t;

    typedef struct packed {
        word_t rdata;
    } mem_rsp_t;

endpackage

//--- design/rv_ifu.sv
`timescale 1ns/1ps

module rv_ifu (
    input  logic                clock,
    input  logic                rst,
    input  logic                retire,
    input  logic                halt,
    output logic                fetch_valid,
    input  logic                fetch_ready,
    input  logic                fetch_rsp_valid,
    input  rv_core_pkg::word_t  fetch_rdata,
    output rv_core_pkg::word_t  inst,
    output logic                inst_valid
);

    rv_core_pkg::ifu_state_t state;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= rv_core_pkg::IFU_IDLE;
        end else begin
            case (state)
                rv_core_pkg::IFU_IDLE: if (!halt) state <= rv_core_pkg::IFU_REQ;
                rv_core_pkg::IFU_REQ:  if (fetch_ready) state <= rv_core_pkg::IFU_WAIT;
                rv_core_pkg::IFU_WAIT: if (fetch_rsp_valid) state <= rv_core_pkg::IFU_HOLD;
                default: begin
                    // Refetch straight away unless this retire halts the core.
                    if (retire) state <= halt ? rv_core_pkg::IFU_IDLE : rv_core_pkg::IFU_REQ;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == rv_core_pkg::IFU_WAIT && fetch_rsp_valid) inst <= fetch_rdata;
    end

    assign fetch_valid = (state == rv_core_pkg::IFU_REQ);
    assign inst_valid  = (state == rv_core_pkg::IFU_HOLD);

    // The arbiter must never route a response here once the word is captured.
    a_no_rsp_in_hold: assert property (@(posedge clock) disable iff (rst)
        state == rv_core_pkg::IFU_HOLD |-> !fetch_rsp_valid);

endmodule

//--- design/rv_idu.sv
`timescale 1ns/1ps

module rv_idu (
    input  rv_core_pkg::word_t     inst,
    output rv_core_pkg::decoded_t  dec
);

    rv_core_pkg::opcode_t opcode;
    logic [2:0] funct3;
    rv_core_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = rv_core_pkg::opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        logic use_rs1, use_rs2, use_rd;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_rd  = 1'b0;
        dec = '0;
        dec.rs1 = inst[18:15];
        dec.rs2 = inst[23:20];
        dec.rd  = inst[10:7];
        dec.alu_op = rv_core_pkg::ALU_ADD;
        dec.br_op  = rv_core_pkg::BR_NONE;
        dec.mem_size = rv_core_pkg::mem_size_t'(funct3[1:0]);
        dec.mem_unsigned = funct3[2];
        case (funct3)   // Shared by OP and OP-IMM.
            3'b000: dec.alu_op = (opcode == rv_core_pkg::OPC_OP && inst[30]) ?
                                 rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            3'b001: dec.alu_op = rv_core_pkg::ALU_SLL;
            3'b010: dec.alu_op = rv_core_pkg::ALU_SLT;
            3'b011: dec.alu_op = rv_core_pkg::ALU_SLTU;
            3'b100: dec.alu_op = rv_core_pkg::ALU_XOR;
            3'b101: dec.alu_op = inst[30] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            3'b110: dec.alu_op = rv_core_pkg::ALU_OR;
            default: dec.alu_op = rv_core_pkg::ALU_AND;
        endcase
        case (opcode)
            rv_core_pkg::OPC_LUI: begin
                {use_rd, dec.reg_write, dec.b_imm, dec.imm} = {3'b111, imm_u};
                dec.alu_op = rv_core_pkg::ALU_PASS_B;
            end
            rv_core_pkg::OPC_AUIPC: begin
                {use_rd, dec.reg_write, dec.a_pc, dec.b_imm, dec.imm} = {4'b1111, imm_u};
                dec.alu_op = rv_core_pkg::ALU_ADD;
            end
            rv_core_pkg::OPC_JAL: begin
                {use_rd, dec.reg_write, dec.imm} = {2'b11, imm_j};
                dec.br_op = rv_core_pkg::BR_JAL;
            end
            rv_core_pkg::OPC_JALR: begin
                {use_rs1, use_rd, dec.reg_write, dec.imm} = {3'b111, imm_i};
                dec.br_op = rv_core_pkg::BR_JALR;
            end
            rv_core_pkg::OPC_BRANCH: begin
                {use_rs1, use_rs2, dec.imm} = {2'b11, imm_b};
                case (funct3)
                    3'b000: dec.br_op = rv_core_pkg::BR_EQ;
                    3'b001: dec.br_op = rv_core_pkg::BR_NE;
                    3'b100: dec.br_op = rv_core_pkg::BR_LT;
                    3'b101: dec.br_op = rv_core_pkg::BR_GE;
                    3'b110: dec.br_op = rv_core_pkg::BR_LTU;
                    3'b111: dec.br_op = rv_core_pkg::BR_GEU;
                    default: dec.illegal = 1'b1;
                endcase
            end
            rv_core_pkg::OPC_LOAD: begin
                {use_rs1, use_rd, dec.reg_write, dec.mem_read, dec.b_imm} = 5'b11111;
                dec.imm = imm_i;
                dec.alu_op = rv_core_pkg::ALU_ADD;
                dec.illegal = (funct3[1:0] == 2'b11) || (funct3[2] && funct3[1]);
            end
            rv_core_pkg::OPC_STORE: begin
                {use_rs1, use_rs2, dec.mem_write, dec.b_imm, dec.imm} = {4'b1111, imm_s};
                dec.alu_op = rv_core_pkg::ALU_ADD;
                dec.illegal = funct3[2] || (funct3[1:0] == 2'b11);
            end
            rv_core_pkg::OPC_OP_IMM: begin
                {use_rs1, use_rd, dec.reg_write, dec.b_imm, dec.imm} = {4'b1111, imm_i};
            end
            rv_core_pkg::OPC_OP: {use_rs1, use_rs2, use_rd, dec.reg_write} = 4'b1111;
            rv_core_pkg::OPC_SYSTEM: begin
                dec.halt = (inst == 32'h0010_0073);   // EBREAK only.
                dec.illegal = !dec.halt;
            end
            default: dec.illegal = 1'b1;
        endcase
        // RV32E has no x16..x31.
        if ((use_rs1 && inst[19]) || (use_rs2 && inst[24]) || (use_rd && inst[11])) begin
            dec.illegal = 1'b1;
        end
        if (dec.illegal) begin
            {dec.reg_write, dec.mem_read, dec.mem_write} = 3'b000;
            dec.br_op = rv_core_pkg::BR_NONE;
        end
    end

endmodule

//--- design/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                   clock,
    input  logic                   we,
    input  rv_core_pkg::reg_idx_t  waddr,
    input  rv_core_pkg::word_t     wdata,
    input  rv_core_pkg::reg_idx_t  raddr1,
    input  rv_core_pkg::reg_idx_t  raddr2,
    output rv_core_pkg::word_t     rdata1,
    output rv_core_pkg::word_t     rdata2
);

    rv_core_pkg::word_t regs [rv_core_pkg::NREGS];

    always_ff @(posedge clock) begin
        if (we && waddr != '0) regs[waddr] <= wdata;
    end

    // Entry 0 is never written, so it is masked on the read side.
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- design/rv_exu.sv
`timescale 1ns/1ps

module rv_exu (
    input  rv_core_pkg::decoded_t  dec,
    input  rv_core_pkg::word_t     pc,
    input  rv_core_pkg::word_t     rs1_d,
    input  rv_core_pkg::word_t     rs2_d,
    output rv_core_pkg::word_t     result,
    output logic                   taken,
    output rv_core_pkg::word_t     target
);

    rv_core_pkg::word_t op_a, op_b, alu_out;
    logic is_jump;

    assign op_a = dec.a_pc ? pc : rs1_d;
    assign op_b = dec.b_imm ? dec.imm : rs2_d;
    assign is_jump = (dec.br_op == rv_core_pkg::BR_JAL) || (dec.br_op == rv_core_pkg::BR_JALR);

    always_comb begin
        case (dec.alu_op)
            rv_core_pkg::ALU_SUB:  alu_out = op_a - op_b;
            rv_core_pkg::ALU_SLL:  alu_out = op_a << op_b[4:0];
            rv_core_pkg::ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_core_pkg::ALU_SLTU: alu_out = {31'b0, op_a < op_b};
            rv_core_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
            rv_core_pkg::ALU_SRL:  alu_out = op_a >> op_b[4:0];
            rv_core_pkg::ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
            rv_core_pkg::ALU_OR:   alu_out = op_a | op_b;
            rv_core_pkg::ALU_AND:  alu_out = op_a & op_b;
            rv_core_pkg::ALU_PASS_B: alu_out = op_b;
            default: alu_out = op_a + op_b;
        endcase
    end

    always_comb begin
        case (dec.br_op)
            rv_core_pkg::BR_EQ:  taken = (rs1_d == rs2_d);
            rv_core_pkg::BR_NE:  taken = (rs1_d != rs2_d);
            rv_core_pkg::BR_LT:  taken = ($signed(rs1_d) < $signed(rs2_d));
            rv_core_pkg::BR_GE:  taken = ($signed(rs1_d) >= $signed(rs2_d));
            rv_core_pkg::BR_LTU: taken = (rs1_d < rs2_d);
            rv_core_pkg::BR_GEU: taken = (rs1_d >= rs2_d);
            default: taken = is_jump;
        endcase
    end

    assign target = (dec.br_op == rv_core_pkg::BR_JALR) ?
                    ((rs1_d + dec.imm) & ~32'd1) : (pc + dec.imm);

    // Jumps write the link address in place of the ALU value.
    assign result = is_jump ? pc + 32'd4 : alu_out;

endmodule

//--- design/rv_pcu.sv
`timescale 1ns/1ps

module rv_pcu (
    input  logic                clock,
    input  logic                rst,
    input  logic                retire,
    input  logic                taken,
    input  rv_core_pkg::word_t  target,
    output rv_core_pkg::word_t  pc
);

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= rv_core_pkg::RESET_PC;
        end else if (retire) begin
            pc <= taken ? target : pc + 32'd4;
        end
    end

    // Branch and jump targets computed in the EXU must keep the PC aligned.
    a_pc_aligned: assert property (@(posedge clock) disable iff (rst)
        retire |=> pc[1:0] == 2'b00);

endmodule

//--- design/rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu (
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   fetch_valid,
    output logic                   fetch_ready,
    input  rv_core_pkg::word_t     fetch_addr,
    output logic                   fetch_rsp_valid,
    input  logic                   data_start,
    input  rv_core_pkg::decoded_t  dec,
    input  rv_core_pkg::word_t     addr,
    input  rv_core_pkg::word_t     store_data,
    output rv_core_pkg::word_t     load_data,
    output logic                   data_done,
    output rv_core_pkg::mem_req_t  mem_req,
    output logic                   mem_req_valid,
    input  logic                   mem_req_ready,
    input  rv_core_pkg::mem_rsp_t  mem_rsp,
    input  logic                   mem_rsp_valid
);

    rv_core_pkg::lsu_state_t state;
    rv_core_pkg::mem_req_t fetch_req, data_req;
    rv_core_pkg::word_t rsp_shifted;
    logic [4:0] lane_shift;
    logic data_valid, data_accept, owner_q;

    assign lane_shift = {addr[1:0], 3'b000};
    // The first cycle is covered by data_start so the request leaves without delay.
    assign data_valid = (state == rv_core_pkg::LSU_REQ) ||
                        (state == rv_core_pkg::LSU_IDLE && data_start);
    assign data_accept = data_valid && !fetch_valid && mem_req_ready;

    assign fetch_req = '{addr: fetch_addr, wdata: '0, strb: '0, we: 1'b0};

    always_comb begin
        data_req.addr  = {addr[31:2], 2'b00};
        data_req.wdata = store_data << lane_shift;
        data_req.we    = dec.mem_write;
        case (dec.mem_size)
            rv_core_pkg::MEM_BYTE: data_req.strb = 4'b0001 << addr[1:0];
            rv_core_pkg::MEM_HALF: data_req.strb = 4'b0011 << addr[1:0];
            default:               data_req.strb = 4'b1111;
        endcase
    end

    // Fetch wins, though the core never lets both sides ask at once.
    assign mem_req       = fetch_valid ? fetch_req : data_req;
    assign mem_req_valid = fetch_valid || data_valid;
    assign fetch_ready   = mem_req_ready;

    always_ff @(posedge clock) begin
        if (rst) begin
            state   <= rv_core_pkg::LSU_IDLE;
            owner_q <= 1'b0;
        end else begin
            if (mem_req_valid && mem_req_ready) owner_q <= fetch_valid;
            case (state)
                rv_core_pkg::LSU_IDLE:
                    if (data_start) state <= data_accept ? rv_core_pkg::LSU_WAIT :
                                                           rv_core_pkg::LSU_REQ;
                rv_core_pkg::LSU_REQ: if (data_accept) state <= rv_core_pkg::LSU_WAIT;
                default: if (data_done) state <= rv_core_pkg::LSU_IDLE;
            endcase
        end
    end

    assign fetch_rsp_valid = mem_rsp_valid && owner_q;
    assign data_done = mem_rsp_valid && !owner_q && state == rv_core_pkg::LSU_WAIT;

    assign rsp_shifted = mem_rsp.rdata >> lane_shift;

    always_comb begin
        case (dec.mem_size)
            rv_core_pkg::MEM_BYTE:
                load_data = {{24{!dec.mem_unsigned && rsp_shifted[7]}}, rsp_shifted[7:0]};
            rv_core_pkg::MEM_HALF:
                load_data = {{16{!dec.mem_unsigned && rsp_shifted[15]}}, rsp_shifted[15:0]};
            default: load_data = mem_rsp.rdata;
        endcase
    end

    a_req_stable: assert property (@(posedge clock) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

endmodule

//--- design/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                   clock,
    input  logic                   rst,
    output rv_core_pkg::mem_req_t  mem_req,
    output logic                   mem_req_valid,
    input  logic                   mem_req_ready,
    input  rv_core_pkg::mem_rsp_t  mem_rsp,
    input  logic                   mem_rsp_valid,
    output rv_core_pkg::word_t     pc,
    output rv_core_pkg::word_t     inst,
    output logic                   retire,
    output logic                   halt
);

    rv_core_pkg::decoded_t dec;
    rv_core_pkg::word_t rs1_d, rs2_d, result, target, load_data;
    logic fetch_valid, fetch_ready, fetch_rsp_valid;
    logic inst_valid, inst_valid_d, taken, data_done, is_mem, halt_inst, halt_next;

    assign is_mem    = dec.mem_read || dec.mem_write;
    assign halt_inst = dec.halt || dec.illegal;
    assign retire    = inst_valid && (is_mem ? data_done : 1'b1);
    assign halt_next = halt || (retire && halt_inst);   // Stops the refetch on the same edge.

    always_ff @(posedge clock) begin
        if (rst) begin
            inst_valid_d <= 1'b0;
            halt <= 1'b0;
        end else begin
            inst_valid_d <= inst_valid;
            halt <= halt_next;
        end
    end

    rv_ifu u_ifu (
        .clock(clock), .rst(rst), .retire(retire), .halt(halt_next),
        .fetch_valid(fetch_valid), .fetch_ready(fetch_ready),
        .fetch_rsp_valid(fetch_rsp_valid), .fetch_rdata(mem_rsp.rdata),
        .inst(inst), .inst_valid(inst_valid)
    );

    rv_idu u_idu (.inst(inst), .dec(dec));

    rv_regfile u_reg (
        .clock(clock), .we(retire && dec.reg_write), .waddr(dec.rd),
        .wdata(dec.mem_read ? load_data : result),
        .raddr1(dec.rs1), .raddr2(dec.rs2), .rdata1(rs1_d), .rdata2(rs2_d)
    );

    rv_exu u_exu (
        .dec(dec), .pc(pc), .rs1_d(rs1_d), .rs2_d(rs2_d),
        .result(result), .taken(taken), .target(target)
    );

    // A halting instruction leaves the PC on itself.
    rv_pcu u_pcu (
        .clock(clock), .rst(rst), .retire(retire && !halt_inst),
        .taken(taken), .target(target), .pc(pc)
    );

    rv_lsu u_lsu (
        .clock(clock), .rst(rst),
        .fetch_valid(fetch_valid), .fetch_ready(fetch_ready), .fetch_addr(pc),
        .fetch_rsp_valid(fetch_rsp_valid),
        .data_start(inst_valid && !inst_valid_d && is_mem), .dec(dec),
        .addr(result), .store_data(rs2_d), .load_data(load_data), .data_done(data_done),
        .mem_req(mem_req), .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
        .mem_rsp(mem_rsp), .mem_rsp_valid(mem_rsp_valid)
    );

endmodule

//--- verif/rv_mem_model.sv
`timescale 1ns/1ps

module rv_mem_model (
    input  logic                   clock,
    input  logic                   rst,
    input  rv_core_pkg::mem_req_t  mem_req,
    input  logic                   mem_req_valid,
    output logic                   mem_req_ready,
    output rv_core_pkg::mem_rsp_t  mem_rsp,
    output logic                   mem_rsp_valid
);

    rv_core_pkg::word_t mem [1024];
    rv_core_pkg::mem_req_t held;
    logic [31:0] lfsr = 32'hb53006fa;
    logic pending = 1'b0;
    int delay = 0;

    function automatic logic take_bit();
        logic b;
        b = lfsr[0];
        lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    initial begin
        mem_req_ready = 1'b0;
        mem_rsp = '0;
        mem_rsp_valid = 1'b0;
    end

    always @(posedge clock) begin
        if (rst) begin
            pending = 1'b0;
        end else if (mem_req_valid && mem_req_ready) begin
            held = mem_req;
            pending = 1'b1;
            delay = take_bit();
            delay = 2 * delay + take_bit();   // Zero to three extra cycles.
            for (int b = 0; b < 4; b++) begin
                if (mem_req.we && mem_req.strb[b]) begin
                    mem[mem_req.addr[11:2]][8*b +: 8] = mem_req.wdata[8*b +: 8];
                end
            end
        end
    end

    // Inputs of the core change only on the falling edge.
    always @(negedge clock) begin
        mem_rsp_valid = 1'b0;
        mem_req_ready = (take_bit() | take_bit()) && !rst;
        if (pending && !rst) begin
            if (delay == 0) begin
                mem_rsp.rdata = mem[held.addr[11:2]];
                mem_rsp_valid = 1'b1;
                pending = 1'b0;
            end else begin
                delay--;
            end
        end
    end

endmodule

//--- verif/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam rv_core_pkg::word_t POISON = 32'hDEAD_BEEF;
    localparam rv_core_pkg::word_t A = 32'h8765_4321;   // Value of x1.
    localparam rv_core_pkg::word_t B = 32'hFFFF_FFFB;   // Value of x2. x3 holds 7.
    localparam rv_core_pkg::word_t LOAD_WORD = 32'h80F1_7F02;
    localparam rv_core_pkg::word_t EBREAK = 32'h0010_0073;

    logic clock = 1'b0;
    logic rst = 1'b1;
    rv_core_pkg::mem_req_t mem_req;
    rv_core_pkg::mem_rsp_t mem_rsp;
    rv_core_pkg::word_t pc, inst, halt_pc;
    rv_core_pkg::word_t slot_exp [rv_core_pkg::word_t];
    int slot_grp [rv_core_pkg::word_t];
    bit slot_seen [rv_core_pkg::word_t];
    logic mem_req_valid, mem_req_ready, mem_rsp_valid, retire, halt;
    logic outstanding = 1'b0;
    logic stalled = 1'b0;
    rv_core_pkg::mem_req_t last_req;
    string names [6] = '{"alu", "loads", "partial stores", "control flow", "handshake", "halt"};
    int errs [6] = '{0, 0, 0, 0, 0, 0};
    int n = 0;
    int prog_len = 0;
    int next_slot = 0;
    int total = 0;

    rv_core dut0 (.*);
    rv_mem_model mem0 (.*);

    initial forever #10 clock = ~clock;

    function automatic rv_core_pkg::word_t i_type(logic [11:0] imm, logic [4:0] rs1,
                                                  logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_core_pkg::word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                                  logic [2:0] f3);
        return {f7, rs2, rs1, f3, 5'd4, 7'h33};   // Result always lands in x4.
    endfunction

    function automatic rv_core_pkg::word_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'h23};
    endfunction

    function automatic rv_core_pkg::word_t b_type(logic [4:0] rs1, logic [4:0] rs2, logic [2:0] f3);
        return {7'b0, rs2, rs1, f3, 5'b01000, 7'h63};   // Always jumps 8 bytes ahead.
    endfunction

    function automatic rv_core_pkg::word_t extend_load(int off, int bytes, bit uns);
        rv_core_pkg::word_t v;
        v = (LOAD_WORD >> (8 * off)) & ((32'd1 << (8 * bytes)) - 32'd1);
        if (!uns && v[8 * bytes - 1]) v = v - (32'd1 << (8 * bytes));   // Two's complement.
        return v;
    endfunction

    task automatic emit(rv_core_pkg::word_t w);
        mem0.mem[n] = w;
        n++;
    endtask

    task automatic store_result(int grp, rv_core_pkg::word_t exp, logic [4:0] rs);
        rv_core_pkg::word_t a;
        a = 32'h400 + 4 * next_slot;
        next_slot++;
        slot_exp[a] = exp;
        slot_grp[a] = grp;
        slot_seen[a] = 1'b0;
        emit(s_type(a[11:0], rs, 3'd2));
    endtask

    task automatic branch_case(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2, bit taken);
        emit(b_type(rs1, rs2, f3));
        if (!taken) emit({20'h00800, 5'd0, 7'h6f});   // JAL x0 past the poison store.
        emit(s_type(12'h7F0, 5'd5, 3'd2));
    endtask

    task automatic build_program();
        for (int i = 0; i < 1024; i++) mem0.mem[i] = 32'hC0DE_0000 | i;
        emit({20'h87654, 5'd1, 7'h37});
        emit(i_type(12'h321, 1, 0, 1, 7'h13));
        emit(i_type(-12'sd5, 0, 0, 2, 7'h13));
        emit(i_type(12'd7, 0, 0, 3, 7'h13));
        emit({20'hDEADC, 5'd5, 7'h37});
        emit(i_type(-12'sd273, 5, 0, 5, 7'h13));
        emit(r_type(0, 2, 1, 0));      store_result(0, A + B, 4);
        emit(r_type(7'h20, 2, 1, 0));  store_result(0, A - B, 4);
        emit(r_type(0, 3, 1, 1));      store_result(0, A << 7, 4);
        emit(r_type(0, 2, 1, 2));      store_result(0, {31'b0, $signed(A) < $signed(B)}, 4);
        emit(r_type(0, 2, 1, 3));      store_result(0, {31'b0, A < B}, 4);
        emit(r_type(0, 2, 1, 4));      store_result(0, A ^ B, 4);
        emit(r_type(0, 3, 1, 5));      store_result(0, A >> 7, 4);
        emit(r_type(7'h20, 3, 1, 5));  store_result(0, $signed(A) >>> 7, 4);
        emit(r_type(0, 2, 1, 6));      store_result(0, A | B, 4);
        emit(r_type(0, 2, 1, 7));      store_result(0, A & B, 4);
        emit(i_type(-12'sd100, 1, 0, 4, 7'h13));  store_result(0, A - 100, 4);
        emit(i_type(-12'sd1, 1, 2, 4, 7'h13));    store_result(0, 32'd1, 4);
        emit(i_type(12'h7FF, 1, 4, 4, 7'h13));    store_result(0, A ^ 32'h7FF, 4);
        emit(i_type(12'h40D, 1, 5, 4, 7'h13));    store_result(0, $signed(A) >>> 13, 4);
        emit(i_type(12'd4, 1, 1, 4, 7'h13));      store_result(0, A << 4, 4);
        emit({20'hABCDE, 5'd4, 7'h37});           store_result(0, 32'hABCD_E000, 4);
        emit({20'h00012, 5'd4, 7'h17});           store_result(0, 4 * (n - 1) + 32'h12000, 4);
        for (int off = 0; off < 4; off++) begin
            emit(i_type(12'h300 + off, 0, 0, 4, 7'h03));  store_result(1, extend_load(off, 1, 0), 4);
            emit(i_type(12'h300 + off, 0, 4, 4, 7'h03));  store_result(1, extend_load(off, 1, 1), 4);
            if (off % 2 == 0) begin
                emit(i_type(12'h300 + off, 0, 1, 4, 7'h03));
                store_result(1, extend_load(off, 2, 0), 4);
                emit(i_type(12'h300 + off, 0, 5, 4, 7'h03));
                store_result(1, extend_load(off, 2, 1), 4);
            end
        end
        emit(i_type(12'h300, 0, 2, 4, 7'h03));  store_result(1, LOAD_WORD, 4);
        emit(s_type(12'h305, 1, 0));
        emit(s_type(12'h30A, 1, 1));
        branch_case(0, 3, 3, 1);  branch_case(0, 1, 3, 0);
        branch_case(1, 1, 3, 1);  branch_case(1, 3, 3, 0);
        branch_case(4, 1, 3, 1);  branch_case(4, 3, 1, 0);
        branch_case(5, 3, 1, 1);  branch_case(5, 1, 3, 0);
        branch_case(6, 3, 1, 1);  branch_case(6, 1, 3, 0);
        branch_case(7, 1, 3, 1);  branch_case(7, 3, 1, 0);
        emit({20'h00800, 5'd8, 7'h6f});   // JAL x8 over the poison store.
        emit(s_type(12'h7F0, 5, 2));
        store_result(3, 4 * (n - 2) + 4, 8);
        emit({20'h00000, 5'd9, 7'h17});
        emit(i_type(12'd12, 9, 0, 10, 7'h67));
        emit(s_type(12'h7F0, 5, 2));
        store_result(3, 4 * (n - 2) + 4, 10);
        halt_pc = 4 * n;
        emit(EBREAK);
        mem0.mem[32'h300 >> 2] = LOAD_WORD;
        mem0.mem[32'h304 >> 2] = 32'hA5A5_A5A5;
        mem0.mem[32'h308 >> 2] = 32'hA5A5_A5A5;
        prog_len = n;
    endtask

    always @(posedge clock) begin
        if (!rst) begin
            assert (!stalled || (mem_req_valid && mem_req == last_req)) else begin
                $display("handshake: a stalled request changed or was withdrawn");
                errs[4]++;
            end
            assert (!(mem_req_valid && mem_req_ready && outstanding && !mem_rsp_valid)) else begin
                $display("handshake: a second request was issued while one was outstanding");
                errs[4]++;
            end
            if (mem_req_valid && mem_req_ready && mem_req.we) begin
                assert (mem_req.wdata != POISON) else begin
                    $display("control flow: a store on the wrong path executed");
                    errs[3]++;
                end
                if (slot_exp.exists(mem_req.addr)) begin
                    slot_seen[mem_req.addr] = 1'b1;
                    assert (mem_req.wdata == slot_exp[mem_req.addr]) else begin
                        $display("[FAIL] %s: expected %h, actual %h", names[slot_grp[mem_req.addr]],
                                 slot_exp[mem_req.addr], mem_req.wdata);
                        errs[slot_grp[mem_req.addr]]++;
                    end
                end
            end
            if (mem_rsp_valid) outstanding = 1'b0;
            if (mem_req_valid && mem_req_ready) outstanding = 1'b1;
            stalled = mem_req_valid && !mem_req_ready;
            last_req = mem_req;
        end
    end

    initial begin
        wait (prog_len > 0);
        #(prog_len * 40 * 20);
        $display("Watchdog: the program did not reach its halt in time");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        build_program();
        repeat (5) begin
            @(negedge clock);
            assert (!mem_req_valid && !retire && !halt) else begin
                $display("halt: an output was not low during reset");
                errs[5]++;
            end
        end
        rst = 1'b0;
        while (!halt) @(negedge clock);
        assert (pc == halt_pc) else begin
            $display("[FAIL] halt: expected %h, actual %h", halt_pc, pc);
            errs[5]++;
        end
        assert (inst == EBREAK) else begin
            $display("[FAIL] halt: expected %h, actual %h", EBREAK, inst);
            errs[5]++;
        end
        repeat (20) begin
            @(negedge clock);
            assert (halt && !mem_req_valid && !retire) else begin
                $display("halt: the core left halt, retired or issued a request");
                errs[5]++;
            end
        end
        foreach (slot_seen[a]) begin
            assert (slot_seen[a]) else begin
                $display("%s: the result store to %h never happened", names[slot_grp[a]], a);
                errs[slot_grp[a]]++;
            end
        end
        assert (mem0.mem[32'h304 >> 2] == 32'hA5A5_21A5) else begin
            $display("[FAIL] partial stores: expected %h, actual %h", 32'hA5A5_21A5,
                     mem0.mem[32'h304 >> 2]);
            errs[2]++;
        end
        assert (mem0.mem[32'h308 >> 2] == 32'h4321_A5A5) else begin
            $display("[FAIL] partial stores: expected %h, actual %h", 32'h4321_A5A5,
                     mem0.mem[32'h308 >> 2]);
            errs[2]++;
        end
        for (int g = 0; g < 6; g++) begin
            $display("%s %s (%0d errors)", errs[g] == 0 ? "PASS" : "FAIL", names[g], errs[g]);
            total += errs[g];
        end
        $display("Test groups: 6, errors: %0d", total);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- sim.f
design/rv_core_pkg.sv
design/rv_ifu.sv
design/rv_idu.sv
design/rv_regfile.sv
design/rv_exu.sv
design/rv_pcu.sv
design/rv_lsu.sv
design/rv_core.sv
verif/rv_mem_model.sv
verif/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - design/rv_core_pkg.sv
  - design/rv_ifu.sv
  - design/rv_idu.sv
  - design/rv_regfile.sv
  - design/rv_exu.sv
  - design/rv_pcu.sv
  - design/rv_lsu.sv
  - design/rv_core.sv
  - target: test
    files:
      - verif/rv_mem_model.sv
      - verif/tb_rv_core.sv
